// ==== hw/rv_decode_pkg.sv ====
package rv_decode_pkg;

  parameter int XLEN = 32;

  // RV32I major opcodes, only the first four are executed
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_BRANCH   = 7'b1100011,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // funct3 values shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = {1'b0, F3_ADD},
    ALU_SUB  = {1'b1, F3_ADD},
    ALU_SLL  = {1'b0, F3_SLL},
    ALU_SLT  = {1'b0, F3_SLT},
    ALU_SLTU = {1'b0, F3_SLTU},
    ALU_XOR  = {1'b0, F3_XOR},
    ALU_SRL  = {1'b0, F3_SR},
    ALU_SRA  = {1'b1, F3_SR},
    ALU_OR   = {1'b0, F3_OR},
    ALU_AND  = {1'b0, F3_AND}
  } alu_op_e;

  typedef struct packed {
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
  } fetch_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    alu_op_e         alu_op;
    logic [4:0]      rd;
  } exec_pkt_t;

  // Writeback to the register file and the core output
  typedef struct packed {
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } wb_t;

endpackage

// ==== hw/inst_fetch.sv ====
`timescale 1ns/1ps

module inst_fetch #(
  parameter logic [rv_decode_pkg::XLEN-1:0] PC_RESET = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inst_valid_i,
  input  logic [31:0]               inst_i,
  output logic                      inst_ready_o,
  output logic                      out_valid_o,
  output rv_decode_pkg::fetch_pkt_t out_o,
  input  logic                      out_ready_i
);

  logic [rv_decode_pkg::XLEN-1:0] pc_q;
  logic                           out_valid_q;
  rv_decode_pkg::fetch_pkt_t      out_q;
  logic                           accept;

  // Slot frees up in the same cycle the buffer takes the current entry
  assign inst_ready_o = !out_valid_q || out_ready_i;
  assign accept       = inst_valid_i && inst_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= PC_RESET;
      out_valid_q <= 1'b0;
    end else if (accept) begin
      pc_q        <= pc_q + 4;
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_q.inst <= inst_i;
      out_q.pc   <= pc_q;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_o       = out_q;

endmodule

// ==== hw/pipe_buffer.sv ====
`timescale 1ns/1ps

module pipe_buffer #(
  parameter type PAYLOAD_T = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid_i,
  input  PAYLOAD_T in_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output PAYLOAD_T out_o,
  input  logic     out_ready_i
);

  logic     out_valid_q;
  PAYLOAD_T out_q;
  logic     skid_valid_q;
  PAYLOAD_T skid_q;
  logic     in_fire;
  logic     out_open;

  // Ready is purely registered, it only drops once the skid entry is taken
  assign in_ready_o = !skid_valid_q;
  assign in_fire    = in_valid_i && in_ready_o;
  assign out_open   = !out_valid_q || out_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_open) begin
      // Skid entry drains first to keep order
      out_valid_q  <= skid_valid_q || in_fire;
      skid_valid_q <= 1'b0;
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_open) begin
      out_q <= skid_valid_q ? skid_q : in_i;
    end else if (in_fire) begin
      skid_q <= in_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_o       = out_q;

endmodule

// ==== hw/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           in_valid_i,
  input  rv_decode_pkg::fetch_pkt_t      in_i,
  output logic                           in_ready_o,
  output logic [4:0]                     rs1_addr_o,
  output logic [4:0]                     rs2_addr_o,
  input  logic [rv_decode_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_decode_pkg::XLEN-1:0] rs2_data_i,
  input  logic [31:0]                    pending_i,
  output logic                           issue_o,
  output logic [4:0]                     issue_rd_o,
  output logic                           out_valid_o,
  output rv_decode_pkg::exec_pkt_t       out_o,
  input  logic                           out_ready_i,
  output logic                           illegal_o
);

  rv_decode_pkg::opcode_e         opcode;
  logic [4:0]                     rs1;
  logic [4:0]                     rs2;
  logic [4:0]                     rd;
  logic [2:0]                     funct3;
  logic                           funct7_b5;
  logic [rv_decode_pkg::XLEN-1:0] imm_i;
  logic [rv_decode_pkg::XLEN-1:0] imm_u;

  logic                           legal;
  logic                           uses_rs1;
  logic                           uses_rs2;
  logic                           stall;
  logic                           fire;
  rv_decode_pkg::exec_pkt_t       pkt_d;

  logic                           out_valid_q;
  rv_decode_pkg::exec_pkt_t       out_q;
  logic                           illegal_q;

  assign opcode    = rv_decode_pkg::opcode_e'(in_i.inst[6:0]);
  assign rd        = in_i.inst[11:7];
  assign funct3    = in_i.inst[14:12];
  assign rs1       = in_i.inst[19:15];
  assign rs2       = in_i.inst[24:20];
  assign funct7_b5 = in_i.inst[30];

  assign imm_i = {{20{in_i.inst[31]}}, in_i.inst[31:20]};
  assign imm_u = {in_i.inst[31:12], 12'b0};

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  always_comb begin
    legal        = 1'b0;
    uses_rs1     = 1'b0;
    uses_rs2     = 1'b0;
    pkt_d.op1    = rs1_data_i;
    pkt_d.op2    = imm_i;
    pkt_d.alu_op = rv_decode_pkg::ALU_ADD;
    pkt_d.rd     = rd;
    case (opcode)
      rv_decode_pkg::OPC_LUI: begin
        legal     = 1'b1;
        pkt_d.op1 = '0;
        pkt_d.op2 = imm_u;
      end
      rv_decode_pkg::OPC_AUIPC: begin
        legal     = 1'b1;
        pkt_d.op1 = in_i.pc;
        pkt_d.op2 = imm_u;
      end
      rv_decode_pkg::OPC_OP_IMM: begin
        legal    = 1'b1;
        uses_rs1 = 1'b1;
        // Only SRAI carries funct7[5], ADDI has no SUB form
        pkt_d.alu_op = rv_decode_pkg::alu_op_e'(
          {(funct3 == rv_decode_pkg::F3_SR) ? funct7_b5 : 1'b0, funct3});
      end
      rv_decode_pkg::OPC_OP: begin
        legal        = 1'b1;
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;
        pkt_d.op2    = rs2_data_i;
        pkt_d.alu_op = rv_decode_pkg::alu_op_e'({funct7_b5, funct3});
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  // Wait for every register this instruction touches to be written back
  assign stall = legal && ((uses_rs1 && pending_i[rs1]) ||
                           (uses_rs2 && pending_i[rs2]) ||
                           pending_i[rd]);

  // One bubble after an illegal instruction keeps illegal_o a single pulse
  assign in_ready_o = !illegal_q && !stall && (!out_valid_q || out_ready_i);
  assign fire       = in_valid_i && in_ready_o;

  assign issue_o    = fire && legal && (rd != 5'd0);
  assign issue_rd_o = rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
      illegal_q   <= 1'b0;
    end else begin
      illegal_q <= fire && !legal;
      if (fire && legal) begin
        out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire && legal) begin
      out_q <= pkt_d;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_o       = out_q;
  assign illegal_o   = illegal_q;

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [4:0]                     rs1_addr_i,
  input  logic [4:0]                     rs2_addr_i,
  output logic [rv_decode_pkg::XLEN-1:0] rs1_data_o,
  output logic [rv_decode_pkg::XLEN-1:0] rs2_data_o,
  input  logic                           wb_valid_i,
  input  rv_decode_pkg::wb_t             wb_i,
  input  logic                           issue_i,
  input  logic [4:0]                     issue_rd_i,
  output logic [31:0]                    pending_o
);

  logic [rv_decode_pkg::XLEN-1:0] regs_q [32];
  logic [31:0]                    pending_q;
  logic [31:0]                    pending_d;

  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs_q[rs2_addr_i];

  // Architectural state starts at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_valid_i && wb_i.rd != 5'd0) begin
      regs_q[wb_i.rd] <= wb_i.data;
    end
  end

  always_comb begin
    pending_d = pending_q;
    if (wb_valid_i) begin
      pending_d[wb_i.rd] = 1'b0;
    end
    if (issue_i) begin
      pending_d[issue_rd_i] = 1'b1;
    end
    pending_d[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  assign pending_o = pending_q;

endmodule

// ==== hw/alu_exec.sv ====
`timescale 1ns/1ps

module alu_exec (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid_i,
  input  rv_decode_pkg::exec_pkt_t in_i,
  output logic                     in_ready_o,
  output logic                     wb_valid_o,
  output rv_decode_pkg::wb_t       wb_o,
  input  logic                     wb_ready_i
);

  logic [rv_decode_pkg::XLEN-1:0] op1;
  logic [rv_decode_pkg::XLEN-1:0] op2;
  logic [4:0]                     shamt;
  logic [rv_decode_pkg::XLEN-1:0] result;
  logic                           fire;
  logic                           wb_valid_q;
  rv_decode_pkg::wb_t             wb_q;

  assign op1   = in_i.op1;
  assign op2   = in_i.op2;
  assign shamt = op2[4:0];

  always_comb begin
    case (in_i.alu_op)
      rv_decode_pkg::ALU_ADD:  result = op1 + op2;
      rv_decode_pkg::ALU_SUB:  result = op1 - op2;
      rv_decode_pkg::ALU_SLL:  result = op1 << shamt;
      rv_decode_pkg::ALU_SLT:  result = {31'b0, $signed(op1) < $signed(op2)};
      rv_decode_pkg::ALU_SLTU: result = {31'b0, op1 < op2};
      rv_decode_pkg::ALU_XOR:  result = op1 ^ op2;
      rv_decode_pkg::ALU_SRL:  result = op1 >> shamt;
      rv_decode_pkg::ALU_SRA:  result = $unsigned($signed(op1) >>> shamt);
      rv_decode_pkg::ALU_OR:   result = op1 | op2;
      rv_decode_pkg::ALU_AND:  result = op1 & op2;
      default:                 result = '0;
    endcase
  end

  // A stalled result blocks the stage
  assign in_ready_o = !wb_valid_q || wb_ready_i;
  assign fire       = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_q <= 1'b0;
    end else if (fire) begin
      wb_valid_q <= 1'b1;
    end else if (wb_ready_i) begin
      wb_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      wb_q.rd   <= in_i.rd;
      wb_q.data <= result;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;

endmodule

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter logic [rv_decode_pkg::XLEN-1:0] PC_RESET = '0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               inst_valid_i,
  input  logic [31:0]        inst_i,
  output logic               inst_ready_o,
  output logic               wb_valid_o,
  output rv_decode_pkg::wb_t wb_o,
  input  logic               wb_ready_i,
  output logic               illegal_o
);

  logic                           fetch_valid;
  logic                           fetch_ready;
  rv_decode_pkg::fetch_pkt_t      fetch_pkt;
  logic                           dec_in_valid;
  logic                           dec_in_ready;
  rv_decode_pkg::fetch_pkt_t      dec_in_pkt;
  logic                           dec_out_valid;
  logic                           dec_out_ready;
  rv_decode_pkg::exec_pkt_t       dec_out_pkt;
  logic                           ex_in_valid;
  logic                           ex_in_ready;
  rv_decode_pkg::exec_pkt_t       ex_in_pkt;
  logic [4:0]                     rs1_addr;
  logic [4:0]                     rs2_addr;
  logic [rv_decode_pkg::XLEN-1:0] rs1_data;
  logic [rv_decode_pkg::XLEN-1:0] rs2_data;
  logic [31:0]                    pending;
  logic                           issue;
  logic [4:0]                     issue_rd;

  // Register file only sees completed writebacks
  wire wb_fire = wb_valid_o & wb_ready_i;

  inst_fetch #(.PC_RESET(PC_RESET)) u_fetch (
    .clk, .rst, .inst_valid_i, .inst_i, .inst_ready_o,
    .out_valid_o(fetch_valid), .out_o(fetch_pkt), .out_ready_i(fetch_ready)
  );

  pipe_buffer #(.PAYLOAD_T(rv_decode_pkg::fetch_pkt_t)) fetch_buf (
    .clk, .rst,
    .in_valid_i(fetch_valid), .in_i(fetch_pkt), .in_ready_o(fetch_ready),
    .out_valid_o(dec_in_valid), .out_o(dec_in_pkt), .out_ready_i(dec_in_ready)
  );

  inst_decode u_decode (
    .clk, .rst,
    .in_valid_i(dec_in_valid), .in_i(dec_in_pkt), .in_ready_o(dec_in_ready),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .pending_i(pending), .issue_o(issue), .issue_rd_o(issue_rd),
    .out_valid_o(dec_out_valid), .out_o(dec_out_pkt), .out_ready_i(dec_out_ready),
    .illegal_o
  );

  reg_file u_regs (
    .clk, .rst,
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .wb_valid_i(wb_fire), .wb_i(wb_o),
    .issue_i(issue), .issue_rd_i(issue_rd), .pending_o(pending)
  );

  pipe_buffer #(.PAYLOAD_T(rv_decode_pkg::exec_pkt_t)) exec_buf (
    .clk, .rst,
    .in_valid_i(dec_out_valid), .in_i(dec_out_pkt), .in_ready_o(dec_out_ready),
    .out_valid_o(ex_in_valid), .out_o(ex_in_pkt), .out_ready_i(ex_in_ready)
  );

  alu_exec u_exec (
    .clk, .rst,
    .in_valid_i(ex_in_valid), .in_i(ex_in_pkt), .in_ready_o(ex_in_ready),
    .wb_valid_o, .wb_o, .wb_ready_i
  );

endmodule

// ==== dv/core_chk.sv ====
`timescale 1ns/1ps

module core_chk (
  input logic               clk,
  input logic               rst,
  input logic               inst_ready_o,
  input logic               wb_valid_o,
  input rv_decode_pkg::wb_t wb_o,
  input logic               wb_ready_i,
  input logic               illegal_o
);

  int fail_count = 0;

  // A stalled writeback must not change
  wb_hold_a: assert property (@(posedge clk) disable iff (rst)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o))
    else begin
      $error("wb_o changed while stalled");
      fail_count++;
    end

  illegal_pulse_a: assert property (@(posedge clk) disable iff (rst)
    illegal_o |=> !illegal_o)
    else begin
      $error("illegal_o high for two cycles");
      fail_count++;
    end

  ctrl_known_a: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({inst_ready_o, wb_valid_o, illegal_o}))
    else begin
      $error("control output unknown");
      fail_count++;
    end

  wb_known_a: assert property (@(posedge clk) disable iff (rst)
    wb_valid_o |-> !$isunknown(wb_o))
    else begin
      $error("wb_o unknown while valid");
      fail_count++;
    end

endmodule

bind rv_core_top core_chk u_core_chk (
  .clk(clk), .rst(rst), .inst_ready_o(inst_ready_o), .wb_valid_o(wb_valid_o),
  .wb_o(wb_o), .wb_ready_i(wb_ready_i), .illegal_o(illegal_o)
);

// ==== dv/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker #(
  parameter logic [31:0] PC_START = 32'h0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               inst_valid_i,
  input  logic [31:0]        inst_i,
  input  logic               inst_ready_o,
  input  logic               wb_valid_o,
  input  rv_decode_pkg::wb_t wb_o,
  input  logic               wb_ready_i,
  input  logic               illegal_o,
  input  int                 test_id_i,
  output int                 errors_o,
  output int                 checks_o,
  output int                 outstanding_o
);

  logic [31:0]        regs [32];
  logic [31:0]        pc;
  rv_decode_pkg::wb_t exp_q [$];
  int                 ill_exp;
  int                 ill_seen;
  int                 test_errs;
  int                 test_wbs;
  int                 last_id;

  function automatic string test_name(input int id);
    case (id)
      1: return "reset_state";
      2: return "basic_ops";
      3: return "dependencies";
      4: return "x0_handling";
      5: return "illegal_ops";
      6: return "back_pressure";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic is_legal(input logic [6:0] opc);
    return (opc == 7'h37) || (opc == 7'h17) || (opc == 7'h13) || (opc == 7'h33);
  endfunction

  // RV32I result from the instruction, its pc and the two source values
  function automatic logic [31:0] ref_exec(input logic [31:0] inst, input logic [31:0] ipc,
                                           input logic [31:0] a, input logic [31:0] rs2v);
    logic [31:0] b;
    logic [31:0] uimm;
    uimm = {inst[31:12], 12'b0};
    if (inst[6:0] == 7'h37) return uimm;
    if (inst[6:0] == 7'h17) return ipc + uimm;
    b = (inst[6:0] == 7'h33) ? rs2v : {{20{inst[31]}}, inst[31:20]};
    case (inst[14:12])
      3'd0: return (inst[6:0] == 7'h33 && inst[30]) ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return inst[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  always @(posedge clk) begin : compare
    rv_decode_pkg::wb_t exp;
    if (rst) begin
      for (int i = 0; i < 32; i++) regs[i] = '0;
      pc = PC_START;
      exp_q.delete();
      ill_exp = 0;
      ill_seen = 0;
      test_errs = 0;
      test_wbs = 0;
      last_id = test_id_i;
      errors_o = 0;
      checks_o = 0;
    end else begin
      if (test_id_i != last_id) begin
        $display("%s: %0d writebacks, %0d errors", test_name(last_id), test_wbs, test_errs);
        test_errs = 0;
        test_wbs = 0;
        last_id = test_id_i;
      end
      if (inst_valid_i && inst_ready_o) begin
        if (is_legal(inst_i[6:0])) begin
          exp.rd = inst_i[11:7];
          exp.data = ref_exec(inst_i, pc, regs[inst_i[19:15]], regs[inst_i[24:20]]);
          exp_q.push_back(exp);
          if (exp.rd != 5'd0) regs[exp.rd] = exp.data;
        end else begin
          ill_exp++;
        end
        pc = pc + 32'd4;
      end
      if (wb_valid_o && wb_ready_i) begin
        checks_o++;
        test_wbs++;
        if (exp_q.size() == 0) begin
          $display("Writeback to rd %0d arrived with no instruction outstanding", wb_o.rd);
          errors_o++;
          test_errs++;
        end else begin
          exp = exp_q.pop_front();
          if (exp !== wb_o) begin
            $display("Mismatch %s: expected rd %0d data %h, actual rd %0d data %h",
                     test_name(last_id), exp.rd, exp.data, wb_o.rd, wb_o.data);
            errors_o++;
            test_errs++;
          end
        end
      end
      if (illegal_o) begin
        ill_seen++;
        if (ill_seen > ill_exp) begin
          $display("Illegal pulse in %s without an illegal instruction", test_name(last_id));
          errors_o++;
          test_errs++;
        end
      end
    end
    outstanding_o = exp_q.size() + ill_exp - ill_seen;
  end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

  localparam logic [31:0] PC_RESET   = 32'h0000_1000;
  localparam int          WAIT_LIMIT = 1000;
  localparam int          DRAIN_LIMIT = 5000;

  logic               clk;
  logic               rst;
  logic               inst_valid_i;
  logic [31:0]        inst_i;
  logic               inst_ready_o;
  logic               wb_valid_o;
  rv_decode_pkg::wb_t wb_o;
  logic               wb_ready_i;
  logic               illegal_o;
  integer             seed;
  logic               bp_en;
  int                 test_id;
  int                 tb_errors;
  int                 chk_errors;
  int                 chk_checks;
  int                 outstanding;
  logic [6:0]         bad_ops [8];

  rv_core_top #(.PC_RESET(PC_RESET)) uut (
    .clk, .rst, .inst_valid_i, .inst_i, .inst_ready_o,
    .wb_valid_o, .wb_o, .wb_ready_i, .illegal_o
  );

  tb_checker #(.PC_START(PC_RESET)) u_checker (
    .clk, .rst, .inst_valid_i, .inst_i, .inst_ready_o, .wb_valid_o, .wb_o,
    .wb_ready_i, .illegal_o, .test_id_i(test_id), .errors_o(chk_errors),
    .checks_o(chk_checks), .outstanding_o(outstanding)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Random output stalls while back-pressure is enabled
  always @(posedge clk) begin
    wb_ready_i <= bp_en ? (($random(seed) & 3) != 0) : 1'b1;
  end

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] rand_legal();
    logic [31:0] r;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic [11:0] imm12;
    r = $random(seed);
    imm = $random(seed);
    f3 = r[19:17];
    imm12 = imm[11:0];
    if (f3 == 3'd1) imm12 = {7'h00, imm[4:0]};
    if (f3 == 3'd5) imm12 = {imm[5] ? 7'h20 : 7'h00, imm[4:0]};
    case (r[1:0])
      2'd0: return {imm[19:0], r[6:2], 7'h37};
      2'd1: return {imm[19:0], r[6:2], 7'h17};
      2'd2: return enc_i(f3, r[6:2], r[11:7], imm12);
      default: return enc_r(((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00,
                            f3, r[6:2], r[11:7], r[16:12]);
    endcase
  endfunction

  task automatic fail_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // Called right after a rising edge, returns after the accepting edge
  task automatic send(input logic [31:0] inst);
    int n;
    n = 0;
    inst_valid_i <= 1'b1;
    inst_i <= inst;
    do begin
      @(negedge clk);
      n++;
    end while (!inst_ready_o && n < WAIT_LIMIT);
    if (!inst_ready_o) begin
      fail_timeout("inst_ready_o");
    end else begin
      @(posedge clk);
      inst_valid_i <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (outstanding != 0 && n < DRAIN_LIMIT);
    if (outstanding != 0) begin
      fail_timeout("outstanding writebacks and illegal pulses");
    end else begin
      @(posedge clk);
    end
  endtask

  initial begin
    int n;
    logic [31:0] r;
    int total_errors;
    seed = 5921;
    bad_ops = '{7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h0f, 7'h73, 7'h7f};
    tb_errors = 0;
    bp_en <= 1'b0;
    wb_ready_i <= 1'b1;
    inst_valid_i <= 1'b0;
    inst_i <= '0;
    test_id <= 1;
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (n = 0; n < 5; n++) begin
      @(negedge clk);
      if (wb_valid_o || illegal_o) begin
        $display("wb_valid_o or illegal_o went high before any input");
        tb_errors++;
      end
    end
    @(posedge clk);
    send(enc_r(7'h00, 3'd0, 5'd5, 5'd1, 5'd2));
    wait_drain();

    test_id <= 2;
    send(enc_i(3'd0, 5'd1, 5'd0, 12'hfb3));
    send({20'habcde, 5'd2, 7'h37});
    send(enc_i(3'd0, 5'd2, 5'd2, 12'h123));
    for (n = 0; n < 8; n++) begin
      send(enc_i(n[2:0], 5'(3 + n), 5'd1, (n == 1 || n == 5) ? 12'h007 : 12'h9a5));
    end
    send(enc_i(3'd5, 5'd11, 5'd1, 12'h409));
    for (n = 0; n < 8; n++) begin
      send(enc_r(7'h00, n[2:0], 5'(12 + n), 5'd1, 5'd2));
    end
    send(enc_r(7'h20, 3'd0, 5'd20, 5'd1, 5'd2));
    send(enc_r(7'h20, 3'd5, 5'd21, 5'd2, 5'd1));
    send({20'h12345, 5'd22, 7'h17});
    wait_drain();

    test_id <= 3;
    for (n = 0; n < 20; n++) begin
      send(enc_r((n % 6 == 0) ? 7'h20 : 7'h00, (n % 2 == 0) ? 3'd0 : 3'd4,
                 5'(13 + (n + 1) % 4), 5'(13 + n % 4), 5'd2));
    end
    for (n = 0; n < 5; n++) send(enc_i(3'd0, 5'd20, 5'd20, 12'h003));
    wait_drain();

    test_id <= 4;
    send(enc_i(3'd0, 5'd0, 5'd1, 12'h005));
    send(enc_r(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));
    send(enc_r(7'h00, 3'd0, 5'd10, 5'd0, 5'd1));
    send(enc_i(3'd6, 5'd11, 5'd0, 12'h000));
    wait_drain();

    test_id <= 5;
    for (n = 0; n < 10; n++) begin
      r = $random(seed);
      send({r[31:7], bad_ops[n % 8]});
      // Back-to-back illegal pair
      if (n % 2 == 1) send({r[31:7], bad_ops[(n + 3) % 8]});
      send({r[31:12], 5'(24 + n % 6), 7'h17});
    end
    wait_drain();

    test_id <= 6;
    bp_en <= 1'b1;
    for (n = 0; n < 200; n++) send(rand_legal());
    wait_drain();
    bp_en <= 1'b0;

    test_id <= 7;
    repeat (2) @(posedge clk);
    total_errors = chk_errors + tb_errors + uut.u_core_chk.fail_count;
    $display("Summary: 6 tests, %0d writebacks checked, %0d errors",
             chk_checks, total_errors);
    if (total_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/rv_decode_pkg.sv
hw/inst_fetch.sv
hw/pipe_buffer.sv
hw/inst_decode.sv
hw/reg_file.sv
hw/alu_exec.sv
hw/rv_core_top.sv
dv/core_chk.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== Makefile ====
TOP      ?= tb_top
FILELIST ?= filelist.f
SRCS     ?= $(shell cat $(FILELIST))
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert -j 0
PASS_MSG ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
